// ==== source/audioPkg.sv ====
package audioPkg;

    typedef logic signed [7:0] sampleT; // Two's complement audio byte

    typedef struct packed {
        logic        enable; // Echo path on, otherwise the live sample passes straight through
        logic [1:0]  gain;   // Echo gain in quarters
        logic [15:0] offset; // Read distance ahead of the write pointer, in bytes
    } echoCfgT;

    // Per-sample sequence of the mixer
    typedef enum logic [1:0] {
        MIX_IDLE,
        MIX_SEARCH,
        MIX_RECORD,
        MIX_OUT
    } mixStateT;

    typedef enum logic [1:0] {
        BUF_IDLE,  // Waiting for a search or record command
        BUF_READ,  // Read request cycle, or a hit on the stored word
        BUF_WRITE, // Record cycle, a real write only on the fourth byte
        BUF_BUSY   // Waiting for the memory to drop busy
    } bufStateT;

    typedef enum logic {WAIT, REQUEST} portStateT; // Reader and writer side of the buffer controller

endpackage

// ==== source/busPkg.sv ====
package busPkg;

    typedef struct packed {
        logic        read;    // One cycle pulse
        logic        write;   // One cycle pulse
        logic [3:0]  select;  // Byte lane enables
        logic [31:0] address; // Byte address, word aligned
        logic [31:0] wdata;
    } sramReqT;

    typedef struct packed {
        logic        busy;  // High for the fixed latency after a request
        logic [31:0] rdata; // Valid once busy falls
    } sramRspT;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

    localparam logic [31:0] sramBase = 32'h3300_0000; // Byte address of buffer word 0

    localparam logic [7:0] regCtrl   = 8'h00; // Enable and invalidate command
    localparam logic [7:0] regOffset = 8'h04;
    localparam logic [7:0] regGain   = 8'h08;
    localparam logic [7:0] regStatus = 8'h0C; // Read only buffer status
endpackage

// ==== source/echoRegs.sv ====
module echoRegs (
    input  logic              clk,
    input  logic              rst,
    input  busPkg::apbReqT    apbReq,
    input  logic              goodData,
    output busPkg::apbRspT    apbRsp,
    output audioPkg::echoCfgT cfg,
    output logic              modeReset
);
    import busPkg::*;

    logic access;      // APB access phase
    logic writeAccess; // Access phase of a write transfer
    logic mapped;      // Address hits one of the four registers

    assign access      = apbReq.psel && apbReq.penable;
    assign writeAccess = access && apbReq.pwrite;
    assign mapped      = apbReq.paddr inside {regCtrl, regOffset, regGain, regStatus};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg       <= '0; // Echo off, zero gain, zero offset
            modeReset <= 1'b0;
        end else begin
            modeReset <= writeAccess && (apbReq.paddr == regCtrl) && apbReq.pwdata[1]; // Self clearing
            if (writeAccess) begin
                case (apbReq.paddr)
                    regCtrl:   cfg.enable <= apbReq.pwdata[0];
                    regOffset: cfg.offset <= apbReq.pwdata[15:0];
                    regGain:   cfg.gain   <= apbReq.pwdata[1:0];
                    default:   cfg        <= cfg; // STATUS and unmapped writes change nothing
                endcase
            end
        end
    end

    always_comb begin
        apbRsp.pready  = apbReq.psel;       // No wait states
        apbRsp.pslverr = access && !mapped; // Error only in the access phase
        case (apbReq.paddr)
            regCtrl:   apbRsp.prdata = {31'b0, cfg.enable}; // Invalidate bit always reads 0
            regOffset: apbRsp.prdata = {16'b0, cfg.offset};
            regGain:   apbRsp.prdata = {30'b0, cfg.gain};
            regStatus: apbRsp.prdata = {31'b0, goodData};
            default:   apbRsp.prdata = '0;
        endcase
    end

    // The master may only raise penable inside a selected transfer
    apbEnableInSelect: assert property (@(posedge clk) disable iff (rst)
        apbReq.penable |-> apbReq.psel);

endmodule

// ==== source/delayLineCtrl.sv ====
module delayLineCtrl #(
    parameter int bufferAddrBits = 13
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      search,
    input  logic                      record,
    input  logic                      modeReset,
    input  logic [bufferAddrBits-1:0] offset,
    input  audioPkg::sampleT          recordSample,
    input  busPkg::sramRspT           sramRsp,
    output busPkg::sramReqT           sramReq,
    output audioPkg::sampleT          delayedSample,
    output logic                      ready,
    output logic                      goodData
);
    import audioPkg::*;
    import busPkg::*;

    localparam int wordBits = bufferAddrBits - 2;

    bufStateT                  bufState, bufNext;
    portStateT                 readPort;    // Memory read outstanding for the current search
    portStateT                 writePort;   // Completed word goes out in this record
    logic [bufferAddrBits-1:0] ptr;         // Next byte to record
    logic [bufferAddrBits-1:0] ptrNext;
    logic [bufferAddrBits-1:0] mark;        // Pointer value that ends the invalid lap
    logic [bufferAddrBits-1:0] target;      // Byte the search returns, wraps with the ring
    logic [wordBits-1:0]       wordAddr;    // Word of the request in flight
    logic [1:0]                readByte;    // Lane of the searched byte within that word
    logic [31:0]               packWord;    // Word being filled by records
    logic [31:0]               storedWord;  // Last word read from memory
    logic [wordBits-1:0]       storedLoc;
    logic                      storedValid;
    logic                      storedHit;   // Search can be served without a read
    logic                      doSearch;    // Searches are dropped until the buffer is trusted
    logic                      idleRecord;

    assign ptrNext    = ptr + 1'b1;
    assign target     = ptr + offset;
    assign doSearch   = search && goodData;
    assign idleRecord = (bufState == BUF_IDLE) && record;
    assign storedHit  = storedValid && (storedLoc == target[bufferAddrBits-1:2]);
    assign ready      = (bufState == BUF_IDLE) && !record && !doSearch;

    always_comb begin
        bufNext = bufState;
        case (bufState)
            BUF_IDLE: begin
                if (record) begin
                    bufNext = BUF_WRITE; // Record wins if both ever arrive together
                end else if (doSearch) begin
                    bufNext = BUF_READ;
                end
            end
            BUF_BUSY: begin
                if (!sramRsp.busy) begin
                    bufNext = BUF_IDLE;
                end
            end
            default: bufNext = BUF_BUSY; // READ and WRITE last exactly one cycle
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bufState <= BUF_IDLE;
        end else begin
            bufState <= bufNext;
        end
    end

    // Pointer, validity lap and writer side
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ptr       <= '0;
            mark      <= '0;
            goodData  <= 1'b0; // A lap must be written after reset as well
            writePort <= WAIT;
        end else begin
            if (modeReset) begin
                mark     <= ptr; // Everything up to a full lap from here is stale
                goodData <= 1'b0;
            end else if (idleRecord && (ptrNext == mark)) begin
                goodData <= 1'b1; // Last stale byte is being overwritten
            end
            if (idleRecord) begin
                ptr       <= ptrNext;
                writePort <= (ptr[1:0] == 2'd3) ? REQUEST : WAIT; // Fourth byte completes the word
            end else if ((bufState == BUF_BUSY) && !sramRsp.busy) begin
                writePort <= WAIT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (idleRecord) begin
            packWord[{ptr[1:0], 3'b000} +: 8] <= recordSample;
            wordAddr                          <= ptr[bufferAddrBits-1:2];
        end else if ((bufState == BUF_IDLE) && doSearch) begin
            wordAddr <= target[bufferAddrBits-1:2];
            readByte <= target[1:0];
        end
    end

    // Reader side with reuse of the last word read
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            readPort      <= WAIT;
            storedValid   <= 1'b0;
            storedLoc     <= '0;
            storedWord    <= '0;
            delayedSample <= '0;
        end else if (!goodData) begin
            readPort      <= WAIT; // Nothing read now can be trusted
            storedValid   <= 1'b0;
            storedLoc     <= '0;
            storedWord    <= '0;
            delayedSample <= '0;
        end else if ((bufState == BUF_IDLE) && doSearch) begin
            if (storedHit) begin
                delayedSample <= storedWord[{target[1:0], 3'b000} +: 8]; // Byte from the held word
            end else begin
                readPort <= REQUEST;
            end
        end else if ((readPort == REQUEST) && (bufState == BUF_BUSY) && !sramRsp.busy) begin
            readPort      <= WAIT;
            storedWord    <= sramRsp.rdata;
            storedLoc     <= wordAddr;
            storedValid   <= 1'b1;
            delayedSample <= sramRsp.rdata[{readByte, 3'b000} +: 8];
        end
    end

    always_comb begin
        sramReq.read    = (bufState == BUF_READ) && (readPort == REQUEST);
        sramReq.write   = (bufState == BUF_WRITE) && (writePort == REQUEST);
        sramReq.select  = 4'hF; // Always whole words
        sramReq.address = sramBase + 32'({wordAddr, 2'b00});
        sramReq.wdata   = packWord;
    end

    // Reader and writer never hold a pending request together, so read and write cannot meet
    readWriteExclusive: assert property (@(posedge clk) disable iff (rst)
        !((readPort == REQUEST) && (writePort == REQUEST)));

    // Request cycles last one cycle and the memory turns busy exactly when a request went out
    requestCycleSingle: assert property (@(posedge clk) disable iff (rst)
        (bufState inside {BUF_READ, BUF_WRITE}) |=>
            (bufState == BUF_BUSY) && (sramRsp.busy == $past(sramReq.read || sramReq.write)));

endmodule

// ==== source/sramWordStore.sv ====
module sramWordStore #(
    parameter int bufferAddrBits = 13,
    parameter int sramLatency    = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  busPkg::sramReqT sramReq,
    output busPkg::sramRspT sramRsp
);
    import busPkg::*;

    localparam int words   = 2 ** (bufferAddrBits - 2);
    localparam int cntBits = $clog2(sramLatency + 1);

    logic [31:0]               mem [words];
    logic [31:0]               byteAddr; // Address relative to the buffer base
    logic [bufferAddrBits-3:0] wordIdx;
    logic [cntBits-1:0]        count;    // Busy cycles still to go
    logic [31:0]               rdataReg;

    assign byteAddr = sramReq.address - sramBase;
    assign wordIdx  = byteAddr[bufferAddrBits-1:2];

    always_comb begin
        sramRsp.busy  = (count != '0);
        sramRsp.rdata = rdataReg; // Held from the request until the next read
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (sramReq.read || sramReq.write) begin
            count <= cntBits'(sramLatency); // Busy starts the cycle after the request
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sramReq.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (sramReq.select[lane]) begin
                    mem[wordIdx][lane*8 +: 8] <= sramReq.wdata[lane*8 +: 8];
                end
            end
        end
        if (sramReq.read) begin
            rdataReg <= mem[wordIdx];
        end
    end

    // The controller must wait out busy before its next request
    noRequestWhileBusy: assert property (@(posedge clk) disable iff (rst)
        sramRsp.busy |-> !(sramReq.read || sramReq.write));

endmodule

// ==== source/echoMixer.sv ====
module echoMixer (
    input  logic              clk,
    input  logic              rst,
    input  audioPkg::echoCfgT cfg,
    input  logic              sampleValid,
    input  audioPkg::sampleT  micSample,
    input  audioPkg::sampleT  delayedSample,
    input  logic              ready,
    output logic              sampleReady,
    output logic              search,
    output logic              record,
    output audioPkg::sampleT  recordSample,
    output audioPkg::sampleT  outSample,
    output logic              outValid
);
    import audioPkg::*;

    mixStateT          mixState;
    logic              waitReady; // Command sent, controller answers from the next cycle
    logic              wet;       // Echo enable seen when the sample was accepted
    logic signed [10:0] scaled;
    logic signed [10:0] sum;
    sampleT            mixed;

    assign sampleReady = (mixState == MIX_IDLE);
    assign search      = (mixState == MIX_SEARCH) && !waitReady;
    assign record      = (mixState == MIX_RECORD) && !waitReady;

    always_comb begin
        scaled = (delayedSample * $signed({1'b0, cfg.gain})) >>> 2; // Floor of delayed * gain / 4
        sum    = scaled + recordSample;
        if (!wet) begin
            mixed = recordSample; // Dry path
        end else if (sum > 11'sd127) begin
            mixed = 8'sd127;
        end else if (sum < -11'sd128) begin
            mixed = -8'sd128;
        end else begin
            mixed = sum[7:0];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            mixState  <= MIX_IDLE;
            waitReady <= 1'b0;
            wet       <= 1'b0;
            outValid  <= 1'b0;
        end else begin
            outValid <= 1'b0;
            case (mixState)
                MIX_IDLE: begin
                    if (sampleValid) begin
                        wet      <= cfg.enable;
                        mixState <= cfg.enable ? MIX_SEARCH : MIX_OUT; // Bypass skips the buffer
                    end
                end
                MIX_SEARCH, MIX_RECORD: begin
                    if (!waitReady) begin
                        waitReady <= 1'b1;
                    end else if (ready) begin
                        waitReady <= 1'b0;
                        mixState  <= (mixState == MIX_SEARCH) ? MIX_RECORD : MIX_OUT;
                    end
                end
                default: begin
                    outValid <= 1'b1;
                    mixState <= MIX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sampleReady && sampleValid) begin
            recordSample <= micSample; // Live sample held for the whole sequence
        end
        if (mixState == MIX_OUT) begin
            outSample <= mixed;
        end
    end

endmodule

// ==== source/echoTop.sv ====
module echoTop #(
    parameter int bufferAddrBits = 13,
    parameter int sramLatency    = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  busPkg::apbReqT   apbReq,
    input  logic             sampleValid,
    input  audioPkg::sampleT micSample,
    output busPkg::apbRspT   apbRsp,
    output logic             sampleReady,
    output audioPkg::sampleT outSample,
    output logic             outValid
);
    import audioPkg::*;
    import busPkg::*;

    echoCfgT cfg;
    logic    modeReset;     // Buffer invalidate pulse
    logic    goodData;
    logic    search;
    logic    record;
    logic    ready;
    sampleT  recordSample;
    sampleT  delayedSample;
    sramReqT sramReq;
    sramRspT sramRsp;

    echoRegs regBlock (
        .clk      (clk),
        .rst      (rst),
        .apbReq   (apbReq),
        .goodData (goodData),
        .apbRsp   (apbRsp),
        .cfg      (cfg),
        .modeReset(modeReset)
    );

    echoMixer mixer (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg),
        .sampleValid  (sampleValid),
        .micSample    (micSample),
        .delayedSample(delayedSample),
        .ready        (ready),
        .sampleReady  (sampleReady),
        .search       (search),
        .record       (record),
        .recordSample (recordSample),
        .outSample    (outSample),
        .outValid     (outValid)
    );

    delayLineCtrl #(.bufferAddrBits(bufferAddrBits)) delayLine (
        .clk          (clk),
        .rst          (rst),
        .search       (search),
        .record       (record),
        .modeReset    (modeReset),
        .offset       (cfg.offset[bufferAddrBits-1:0]), // Offset wraps with the ring size
        .recordSample (recordSample),
        .sramRsp      (sramRsp),
        .sramReq      (sramReq),
        .delayedSample(delayedSample),
        .ready        (ready),
        .goodData     (goodData)
    );

    sramWordStore #(
        .bufferAddrBits(bufferAddrBits),
        .sramLatency   (sramLatency)
    ) sramStore (
        .clk    (clk),
        .rst    (rst),
        .sramReq(sramReq),
        .sramRsp(sramRsp)
    );

endmodule

// ==== testbench/echoTb.sv ====
module echoTb;
    timeunit 1ns;
    timeprecision 100ps;
    import audioPkg::*;
    import busPkg::*;

    localparam int addrBits        = 6;               // 64 byte ring keeps the laps short
    localparam int ringSize        = 2 ** addrBits;
    localparam int clkPeriod       = 8;
    localparam int totalSamples    = 328;             // Sum of all samples sent by the tests below
    localparam int cyclesPerSample = 24;              // Read miss, word write and handshake slack
    localparam int marginCycles    = 1000;            // Reset and APB traffic
    localparam logic [31:0] lfsrTaps = 32'h8020_0003; // Galois form of a maximal 32 bit polynomial

    logic        clk;
    logic        rst;
    apbReqT      apbReq;
    apbRspT      apbRsp;
    logic        sampleValid;
    sampleT      micSample;
    logic        sampleReady;
    sampleT      outSample;
    logic        outValid;
    logic [31:0] lfsr = 32'hc7b8_5d9f;
    sampleT      hist[$];  // Samples recorded since the last invalidate
    bit          curEnable;
    int          curGain;
    int          curOffset;
    int          mismatches;
    int          failures;
    int          sent;

    echoTop #(.bufferAddrBits(addrBits)) UUT (
        .clk        (clk),
        .rst        (rst),
        .apbReq     (apbReq),
        .sampleValid(sampleValid),
        .micSample  (micSample),
        .apbRsp     (apbRsp),
        .sampleReady(sampleReady),
        .outSample  (outSample),
        .outValid   (outValid)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic void wrongValue(input string name, input int expected, input int actual);
        $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        mismatches++;
    endfunction

    function automatic void reportProblem(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        failures++;
    endfunction

    function automatic logic [7:0] randomByte();
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < 8; i++) begin
            value = {value[6:0], lfsr[0]}; // One LFSR step per bit taken
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ lfsrTaps) : (lfsr >> 1);
        end
        return value;
    endfunction

    // Echo rule: sample n hears sample n+offset-ringSize once a full lap is recorded
    function automatic sampleT expectNext(input sampleT live);
        int n;
        int delayed;
        int sum;
        n       = hist.size();
        delayed = 0;
        if (!curEnable) begin
            return live; // Bypass records nothing
        end
        if (n >= ringSize) begin
            delayed = hist[n + curOffset - ringSize];
        end
        sum = int'(live) + ((delayed * curGain) >>> 2); // Arithmetic shift gives the floor
        hist.push_back(live);
        if (sum > 127) begin
            return 8'sd127;
        end else if (sum < -128) begin
            return -8'sd128;
        end
        return sampleT'(sum);
    endfunction

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        apbReq.psel   <= 1'b1;
        apbReq.pwrite <= 1'b1;
        apbReq.paddr  <= addr;
        apbReq.pwdata <= data;
        @(posedge clk);
        apbReq.penable <= 1'b1;
        @(negedge clk); // Middle of the access cycle
        if (!apbRsp.pready) reportProblem($sformatf("pready low on a write to 0x%h", addr));
        if (apbRsp.pslverr) reportProblem($sformatf("pslverr on a write to 0x%h", addr));
        @(posedge clk); // Write lands on this edge
        apbReq.psel    <= 1'b0;
        apbReq.penable <= 1'b0;
        apbReq.pwrite  <= 1'b0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output bit err);
        @(posedge clk);
        apbReq.psel   <= 1'b1;
        apbReq.pwrite <= 1'b0;
        apbReq.paddr  <= addr;
        @(posedge clk);
        apbReq.penable <= 1'b1;
        @(negedge clk);
        data = apbRsp.prdata;
        err  = apbRsp.pslverr;
        if (!apbRsp.pready) reportProblem($sformatf("pready low on a read of 0x%h", addr));
        @(posedge clk);
        apbReq.psel    <= 1'b0;
        apbReq.penable <= 1'b0;
    endtask

    task automatic expectReg(input logic [7:0] addr, input string name, input int expected);
        logic [31:0] data;
        bit          err;
        apbRead(addr, data, err);
        if (err) reportProblem($sformatf("pslverr on a read of %s", name));
        if (data !== expected) wrongValue(name, expected, int'(data));
    endtask

    task automatic configure(input bit enable, input int gain, input int offset, input bit inval);
        apbWrite(regGain, gain);
        apbWrite(regOffset, offset);
        apbWrite(regCtrl, {30'b0, inval, enable});
        curEnable = enable;
        curGain   = gain;
        curOffset = offset;
        if (inval) hist.delete(); // Model history restarts with the buffer
    endtask

    task automatic sendSample(input sampleT live, input bit timed);
        sampleT expected;
        int     latency;
        expected = expectNext(live);
        @(posedge clk);
        sampleValid <= 1'b1;
        micSample   <= live;
        @(negedge clk);
        while (!sampleReady) @(negedge clk);
        @(posedge clk); // Handshake edge
        sampleValid <= 1'b0;
        sent++;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
            if (!outValid && sampleReady) begin
                reportProblem("sampleReady high while the accepted sample is still in flight");
            end
        end while (!outValid);
        if (outSample !== expected) wrongValue("outSample", expected, outSample);
        if (timed && latency != 2) begin
            reportProblem($sformatf("bypass output came %0d cycles after acceptance", latency));
        end
    endtask

    // Keeps sampleValid high so each new sample waits out sampleReady low
    task automatic streamSamples(input int count, input bit big);
        sampleT expQ[$];
        sampleT live;
        int     highClips;
        int     lowClips;
        highClips = 0;
        lowClips  = 0;
        fork
            begin
                @(posedge clk);
                for (int i = 0; i < count; i++) begin
                    if (!big) begin
                        live = sampleT'(randomByte());
                    end else if (i < count / 2) begin
                        live = sampleT'(100 + int'(randomByte() & 8'd27)); // 100 to 127
                    end else begin
                        live = sampleT'(-100 - int'(randomByte() & 8'd28)); // -100 to -128
                    end
                    expQ.push_back(expectNext(live));
                    sampleValid <= 1'b1;
                    micSample   <= live;
                    @(negedge clk);
                    while (!sampleReady) @(negedge clk);
                    @(posedge clk);
                    sent++;
                end
                sampleValid <= 1'b0;
            end
            begin
                for (int k = 0; k < count; k++) begin
                    do @(negedge clk); while (!outValid);
                    if (expQ.size() == 0) begin
                        reportProblem("output pulse with no sample accepted");
                    end else if (outSample !== expQ[0]) begin
                        wrongValue("outSample", expQ.pop_front(), outSample);
                    end else begin
                        void'(expQ.pop_front());
                    end
                    highClips += (outSample == 8'sd127);
                    lowClips  += (outSample == -8'sd128);
                end
            end
        join
        repeat (20) begin // Longer than a read miss followed by a word write
            @(negedge clk);
            if (outValid) reportProblem("extra output pulse after the burst");
        end
        if (big && (highClips == 0 || lowClips == 0)) reportProblem("burst never saturated");
    endtask

    task automatic registerAccess();
        logic [31:0] data;
        bit          err;
        apbWrite(regOffset, 32'h0000_1234);
        expectReg(regOffset, "prdata OFFSET", 32'h1234);
        apbWrite(regGain, 32'd2);
        expectReg(regGain, "prdata GAIN", 2);
        apbWrite(regCtrl, 32'd3); // Enable plus invalidate
        hist.delete();
        expectReg(regCtrl, "prdata CTRL", 1); // Invalidate bit reads back 0
        expectReg(regStatus, "prdata STATUS", 0);
        apbRead(8'h10, data, err);
        if (!err) reportProblem("pslverr not raised for address 0x10");
    endtask

    task automatic bypassPath();
        configure(1'b0, 0, 0, 1'b0);
        repeat (8) sendSample(sampleT'(randomByte()), 1'b1);
    endtask

    task automatic warmUp();
        configure(1'b1, 3, 0, 1'b1);
        repeat (ringSize - 1) sendSample(sampleT'(randomByte()), 1'b0);
        expectReg(regStatus, "prdata STATUS", 0); // One byte short of a lap
        sendSample(sampleT'(randomByte()), 1'b0);
        expectReg(regStatus, "prdata STATUS", 1);
    endtask

    task automatic echoMix();
        int offsets[2];
        offsets = '{0, 40}; // 40 keeps consecutive reads in one stored word
        foreach (offsets[o]) begin
            for (int g = 1; g <= 3; g++) begin
                configure(1'b1, g, offsets[o], 1'b0);
                repeat (24) sendSample(sampleT'(randomByte()), 1'b0);
            end
        end
    endtask

    task automatic saturationBurst();
        configure(1'b1, 3, 60, 1'b0); // Each sample hears the one four places back
        streamSamples(16, 1'b1);
        streamSamples(24, 1'b0);
    endtask

    task automatic midStreamInvalidate();
        configure(1'b1, 3, 60, 1'b1);
        expectReg(regStatus, "prdata STATUS", 0);
        repeat (ringSize + 8) sendSample(sampleT'(randomByte()), 1'b0);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        apbReq      = '0;
        sampleValid = 1'b0;
        micSample   = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        registerAccess();
        bypassPath();
        warmUp();
        echoMix();
        saturationBurst();
        midStreamInvalidate();
        repeat (4) @(posedge clk);
        $display("Samples sent: %0d, value mismatches: %0d, other failures: %0d",
                 sent, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #((totalSamples * cyclesPerSample + marginCycles) * clkPeriod);
        $display("Watchdog expired after %0d samples, the DUT stopped responding", sent);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== files.f ====
source/audioPkg.sv
source/busPkg.sv
source/echoRegs.sv
source/delayLineCtrl.sv
source/sramWordStore.sv
source/echoMixer.sv
source/echoTop.sv
testbench/echoTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the echo testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module echoTb -f files.f -o echoSim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/echoSim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see sim.log"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
